// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

	// one datapath word
	typedef logic [31:0] word_t;
	// index into the 32-entry register file
	typedef logic [4:0] reg_addr_t;
	// raw immediate field of an i-type word
	typedef logic [15:0] half_t;

	// all-zero data word
	localparam word_t ZERO_WORD = 32'h0000_0000;
	// link register written by jal
	localparam reg_addr_t REG_RA = 5'd31;

	// i-type view: opcode, source, target, immediate
	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t  rs;
		reg_addr_t  rt;
		half_t      imm;
	} itype_t;

	// j-type view: opcode and 26-bit word index
	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] index;
	} jtype_t;

	// one instruction word seen through either view
	typedef union packed {
		itype_t itype;
		jtype_t jtype;
	} inst_u;

	// decoded operation handed to execute
	typedef enum logic [3:0] {
		OP_INVALID,
		OP_ORI,
		OP_ANDI,
		OP_XORI,
		OP_LUI,
		OP_ADDI,
		OP_ADDIU,
		OP_SLTI,
		OP_SLTIU,
		OP_J,
		OP_JAL
	} oper_t;

	// primary opcodes, immediate arithmetic group
	localparam logic [5:0] OPC_ADDI  = 6'b001000;
	localparam logic [5:0] OPC_ADDIU = 6'b001001;
	localparam logic [5:0] OPC_SLTI  = 6'b001010;
	localparam logic [5:0] OPC_SLTIU = 6'b001011;
	// immediate logical group, zero-extended
	localparam logic [5:0] OPC_ANDI  = 6'b001100;
	localparam logic [5:0] OPC_ORI   = 6'b001101;
	localparam logic [5:0] OPC_XORI  = 6'b001110;
	localparam logic [5:0] OPC_LUI   = 6'b001111;
	// pseudo-direct jumps
	localparam logic [5:0] OPC_J     = 6'b000010;
	localparam logic [5:0] OPC_JAL   = 6'b000011;

endpackage

// ==== logic/id_type_i.sv ====
`timescale 1ns/100ps

module id_type_i import cpu_pkg::*; (
	// full instruction word, read through the i-type view
	input  inst_u     inst_i,
	// decoded operation, OP_INVALID when not i-type
	output oper_t     op_o,
	// destination register, always rt for this group
	output reg_addr_t waddr_o,
	// immediate must be zero-extended
	output logic      unsigned_imm_o
);

// fields of the i-type view
logic [5:0] opcode;
reg_addr_t  rt;

assign opcode = inst_i.itype.opcode;
assign rt     = inst_i.itype.rt;

always_comb begin
	op_o           = OP_INVALID;
	unsigned_imm_o = 1'b0;
	case (opcode)
		// logical ops take the immediate as unsigned
		OPC_ORI: begin
			op_o           = OP_ORI;
			unsigned_imm_o = 1'b1;
		end
		OPC_ANDI: begin
			op_o           = OP_ANDI;
			unsigned_imm_o = 1'b1;
		end
		OPC_XORI: begin
			op_o           = OP_XORI;
			unsigned_imm_o = 1'b1;
		end
		// lui only shifts the field up in execute so no sign is needed
		OPC_LUI: begin
			op_o           = OP_LUI;
			unsigned_imm_o = 1'b1;
		end
		// arithmetic and compare ops sign-extend
		OPC_ADDI: begin
			op_o = OP_ADDI;
		end
		OPC_ADDIU: begin
			op_o = OP_ADDIU;
		end
		OPC_SLTI: begin
			op_o = OP_SLTI;
		end
		OPC_SLTIU: begin
			op_o = OP_SLTIU;
		end
		default: begin
			op_o = OP_INVALID;
		end
	endcase

	// no target register unless the opcode matched
	if (op_o != OP_INVALID) begin
		waddr_o = rt;
	end else begin
		waddr_o = '0;
	end
end

endmodule

// ==== logic/id_type_j.sv ====
`timescale 1ns/100ps

module id_type_j import cpu_pkg::*; (
	// full instruction word, read through the j-type view
	input  inst_u inst_i,
	// address of the jump itself
	input  word_t pc_i,
	output oper_t op_o,
	// jal writes the return address
	output logic  link_o,
	output word_t target_o
);

// region bits come from the delay slot address
word_t pc_plus4;

assign pc_plus4 = pc_i + 32'd4;

always_comb begin
	case (inst_i.jtype.opcode)
		OPC_J:   op_o = OP_J;
		OPC_JAL: op_o = OP_JAL;
		default: op_o = OP_INVALID;
	endcase
end

assign link_o = (op_o == OP_JAL);

// pseudo-direct target: 256 MB region of pc+4, word index, byte offset zero
assign target_o = {pc_plus4[31:28], inst_i.jtype.index, 2'b00};

endmodule

// ==== logic/regfile.sv ====
`timescale 1ns/100ps

module regfile import cpu_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_i,
	// write-back port
	input  logic      we_i,
	input  reg_addr_t waddr_i,
	input  word_t     wdata_i,
	// two asynchronous read ports
	input  reg_addr_t raddr1_i,
	input  reg_addr_t raddr2_i,
	output word_t     rdata1_o,
	output word_t     rdata2_o
);

// register 0 has no storage
word_t regs [1:31];

// read with write-first bypass of the write-back port
function automatic word_t read_port(input reg_addr_t raddr);
	word_t data;
	if (raddr == '0) begin
		data = ZERO_WORD;
	end else if (we_i && (waddr_i == raddr)) begin
		data = wdata_i;
	end else begin
		data = regs[raddr];
	end
	return data;
endfunction

always_ff @(posedge clk_i) begin
	if (rst_i) begin
		for (int i = 1; i < 32; i++) begin
			regs[i] <= ZERO_WORD;
		end
	end else if (we_i && (waddr_i != '0)) begin
		// writes to $zero are dropped
		regs[waddr_i] <= wdata_i;
	end
end

// re-evaluated on storage and write-back changes as well as the address
always_comb begin
	rdata1_o = read_port(raddr1_i);
	rdata2_o = read_port(raddr2_i);
end

// $zero reads as zero on both ports even while being written
a_zero_rd1: assert property (@(posedge clk_i) disable iff (rst_i)
	(raddr1_i == '0) |-> (rdata1_o == ZERO_WORD))
	else $error("regfile port 1 returned nonzero for $zero");

a_zero_rd2: assert property (@(posedge clk_i) disable iff (rst_i)
	(raddr2_i == '0) |-> (rdata2_o == ZERO_WORD))
	else $error("regfile port 2 returned nonzero for $zero");

endmodule

// ==== logic/cpu_id.sv ====
`timescale 1ns/100ps

module cpu_id import cpu_pkg::*; (
	input  word_t     pc_i,
	input  inst_u     inst_i,
	// raw register file data for rs and rt
	input  word_t     reg1_i,
	input  word_t     reg2_i,
	// result leaving execute this cycle
	input  logic      ex_we_i,
	input  reg_addr_t ex_waddr_i,
	input  word_t     ex_wdata_i,
	// result leaving memory this cycle
	input  logic      mem_we_i,
	input  reg_addr_t mem_waddr_i,
	input  word_t     mem_wdata_i,
	// read addresses toward the register file
	output reg_addr_t reg_raddr1_o,
	output reg_addr_t reg_raddr2_o,
	// decoded bundle for the id/ex register
	output oper_t     op_o,
	output word_t     reg1_o,
	output word_t     reg2_o,
	output logic      reg_we_o,
	output reg_addr_t reg_waddr_o,
	output word_t     target_o
);

// i-type source fields
reg_addr_t rs;
reg_addr_t rt;
half_t     imm;

assign rs  = inst_i.itype.rs;
assign rt  = inst_i.itype.rt;
assign imm = inst_i.itype.imm;

assign reg_raddr1_o = rs;
assign reg_raddr2_o = rt;

// hazard-free operand value
word_t safe_rs;

// priority: $zero, then ex, then mem, then register file
function automatic word_t fwd_operand(
	input reg_addr_t addr,
	input word_t     rf_data
);
	word_t data;
	if (addr == '0) begin
		data = ZERO_WORD;
	end else if (ex_we_i && (ex_waddr_i == addr)) begin
		data = ex_wdata_i;
	end else if (mem_we_i && (mem_waddr_i == addr)) begin
		data = mem_wdata_i;
	end else begin
		data = rf_data;
	end
	return data;
endfunction

// follows the forwarding ports as well as the address
always_comb begin
	safe_rs = fwd_operand(rs, reg1_i);
end

// both extensions of the immediate
word_t imm_zext;
word_t imm_sext;

assign imm_zext = {16'h0000, imm};
assign imm_sext = {{16{imm[15]}}, imm};

// i-type decoder
oper_t     op_type_i;
reg_addr_t waddr_type_i;
logic      unsigned_imm_type_i;

id_type_i u_id_type_i (
	.inst_i         (inst_i),
	.op_o           (op_type_i),
	.waddr_o        (waddr_type_i),
	.unsigned_imm_o (unsigned_imm_type_i)
);

// j-type decoder
oper_t op_type_j;
logic  link_type_j;
word_t target_type_j;

id_type_j u_id_type_j (
	.inst_i   (inst_i),
	.pc_i     (pc_i),
	.op_o     (op_type_j),
	.link_o   (link_type_j),
	.target_o (target_type_j)
);

logic i_valid;
logic j_valid;

assign i_valid = (op_type_i != OP_INVALID);
assign j_valid = (op_type_j != OP_INVALID);

always_comb begin
	if (i_valid) begin
		op_o        = op_type_i;
		reg1_o      = safe_rs;
		reg2_o      = unsigned_imm_type_i ? imm_zext : imm_sext;
		reg_we_o    = 1'b1;
		reg_waddr_o = waddr_type_i;
		target_o    = ZERO_WORD;
	end else if (j_valid) begin
		op_o        = op_type_j;
		reg1_o      = ZERO_WORD;
		reg2_o      = ZERO_WORD;
		// only jal links into $ra
		reg_we_o    = link_type_j;
		reg_waddr_o = REG_RA;
		target_o    = target_type_j;
	end else begin
		op_o        = OP_INVALID;
		reg1_o      = ZERO_WORD;
		reg2_o      = ZERO_WORD;
		reg_we_o    = 1'b0;
		reg_waddr_o = '0;
		target_o    = ZERO_WORD;
	end
end

// opcode spaces of the two decoders are disjoint
// checked once the word has settled
always_comb begin
	a_one_decoder: assert final (!(i_valid && j_valid))
		else $error("i-type and j-type decoders both claimed opcode");
end

endmodule

// ==== logic/id_stage_top.sv ====
`timescale 1ns/100ps

module id_stage_top import cpu_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_i,
	// instruction from fetch, taken every cycle
	input  word_t     pc_i,
	input  inst_u     inst_i,
	// register file write-back
	input  logic      wb_we_i,
	input  reg_addr_t wb_waddr_i,
	input  word_t     wb_wdata_i,
	// forwarding from execute
	input  logic      ex_we_i,
	input  reg_addr_t ex_waddr_i,
	input  word_t     ex_wdata_i,
	// forwarding from memory
	input  logic      mem_we_i,
	input  reg_addr_t mem_waddr_i,
	input  word_t     mem_wdata_i,
	// id/ex stage register toward execute
	output oper_t     id_ex_op_o,
	output word_t     id_ex_reg1_o,
	output word_t     id_ex_reg2_o,
	output logic      id_ex_we_o,
	output reg_addr_t id_ex_waddr_o,
	output word_t     id_ex_target_o
);

// register file read path
reg_addr_t rf_raddr1;
reg_addr_t rf_raddr2;
word_t     rf_rdata1;
word_t     rf_rdata2;

regfile u_regfile (
	.clk_i    (clk_i),
	.rst_i    (rst_i),
	.we_i     (wb_we_i),
	.waddr_i  (wb_waddr_i),
	.wdata_i  (wb_wdata_i),
	.raddr1_i (rf_raddr1),
	.raddr2_i (rf_raddr2),
	.rdata1_o (rf_rdata1),
	.rdata2_o (rf_rdata2)
);

// combinational decode result of this cycle
oper_t     id_op;
word_t     id_reg1;
word_t     id_reg2;
logic      id_we;
reg_addr_t id_waddr;
word_t     id_target;

cpu_id u_cpu_id (
	.pc_i         (pc_i),
	.inst_i       (inst_i),
	.reg1_i       (rf_rdata1),
	.reg2_i       (rf_rdata2),
	.ex_we_i      (ex_we_i),
	.ex_waddr_i   (ex_waddr_i),
	.ex_wdata_i   (ex_wdata_i),
	.mem_we_i     (mem_we_i),
	.mem_waddr_i  (mem_waddr_i),
	.mem_wdata_i  (mem_wdata_i),
	.reg_raddr1_o (rf_raddr1),
	.reg_raddr2_o (rf_raddr2),
	.op_o         (id_op),
	.reg1_o       (id_reg1),
	.reg2_o       (id_reg2),
	.reg_we_o     (id_we),
	.reg_waddr_o  (id_waddr),
	.target_o     (id_target)
);

// id/ex register, one cycle of latency, no stall input
always_ff @(posedge clk_i) begin
	if (rst_i) begin
		id_ex_op_o     <= OP_INVALID;
		id_ex_reg1_o   <= ZERO_WORD;
		id_ex_reg2_o   <= ZERO_WORD;
		id_ex_we_o     <= 1'b0;
		id_ex_waddr_o  <= '0;
		id_ex_target_o <= ZERO_WORD;
	end else begin
		id_ex_op_o     <= id_op;
		id_ex_reg1_o   <= id_reg1;
		id_ex_reg2_o   <= id_reg2;
		id_ex_we_o     <= id_we;
		id_ex_waddr_o  <= id_waddr;
		id_ex_target_o <= id_target;
	end
end

// a bubble, never a write, follows reset into execute
a_rst_bubble: assert property (@(posedge clk_i)
	rst_i |=> (!id_ex_we_o && (id_ex_op_o == OP_INVALID)))
	else $error("id/ex not a bubble after reset");

endmodule

// ==== verif/tb_id_tasks.svh ====
`ifndef TB_ID_TASKS_SVH
`define TB_ID_TASKS_SVH

function automatic word_t make_itype(input logic [5:0] opc, input reg_addr_t rs,
	input reg_addr_t rt, input half_t imm);
	return {opc, rs, rt, imm};
endfunction

// n-th of the eight i-type opcodes
function automatic logic [5:0] itype_opcode(input int idx);
	case (idx)
		0: return OPC_ORI;
		1: return OPC_ANDI;
		2: return OPC_XORI;
		3: return OPC_LUI;
		4: return OPC_ADDI;
		5: return OPC_ADDIU;
		6: return OPC_SLTI;
		default: return OPC_SLTIU;
	endcase
endfunction

function automatic oper_t expected_op(input logic [5:0] opc);
	case (opc)
		OPC_ORI:   return OP_ORI;
		OPC_ANDI:  return OP_ANDI;
		OPC_XORI:  return OP_XORI;
		OPC_LUI:   return OP_LUI;
		OPC_ADDI:  return OP_ADDI;
		OPC_ADDIU: return OP_ADDIU;
		OPC_SLTI:  return OP_SLTI;
		OPC_SLTIU: return OP_SLTIU;
		OPC_J:     return OP_J;
		OPC_JAL:   return OP_JAL;
		default:   return OP_INVALID;
	endcase
endfunction

// logical ops and lui zero-extend, the rest sign-extend
function automatic word_t expected_imm(input logic [5:0] opc, input half_t imm);
	if (opc == OPC_ORI || opc == OPC_ANDI || opc == OPC_XORI || opc == OPC_LUI) begin
		return {16'h0000, imm};
	end
	return {{16{imm[15]}}, imm};
endfunction

// $zero, then ex, then mem, then the register file
function automatic word_t expected_operand(input reg_addr_t addr);
	if (addr == 5'd0) begin
		return ZERO_WORD;
	end
	if (ex_we && ex_waddr == addr) begin
		return ex_wdata;
	end
	if (mem_we && mem_waddr == addr) begin
		return mem_wdata;
	end
	return shadow_regs[addr];
endfunction

function automatic word_t expected_target(input word_t pc_val, input logic [25:0] index);
	word_t next_pc;
	next_pc = pc_val + 32'd4;
	return {next_pc[31:28], index, 2'b00};
endfunction

task automatic check_outputs(input oper_t op, input word_t reg1, input word_t reg2,
	input logic we, input reg_addr_t waddr, input word_t target);
	check_value("id_ex_op_o", 32'(id_ex_op), 32'(op));
	check_value("id_ex_reg1_o", id_ex_reg1, reg1);
	check_value("id_ex_reg2_o", id_ex_reg2, reg2);
	check_value("id_ex_we_o", 32'(id_ex_we), 32'(we));
	check_value("id_ex_waddr_o", 32'(id_ex_waddr), 32'(waddr));
	check_value("id_ex_target_o", id_ex_target, target);
endtask

// drive one i-type word, result shows up after the next edge
task automatic check_itype(input logic [5:0] opc, input reg_addr_t rs, input reg_addr_t rt,
	input half_t imm, input word_t exp_reg1);
	inst = make_itype(opc, rs, rt, imm);
	step();
	check_outputs(expected_op(opc), exp_reg1, expected_imm(opc, imm), 1'b1, rt, ZERO_WORD);
endtask

task automatic write_reg(input reg_addr_t addr, input word_t data);
	wb_we    = 1'b1;
	wb_waddr = addr;
	wb_wdata = data;
	step();
	wb_we = 1'b0;
	if (addr != 5'd0) begin
		shadow_regs[addr] = data;
	end
endtask

task automatic test_reset();
	check_outputs(OP_INVALID, ZERO_WORD, ZERO_WORD, 1'b0, 5'd0, ZERO_WORD);
endtask

// negative immediates tell zero- from sign-extension apart
task automatic test_itype_decode();
	for (int i = 0; i < 8; i++) begin
		check_itype(itype_opcode(i), 5'(i + 1), 5'(i + 9), 16'(16'hff80 - i),
			expected_operand(5'(i + 1)));
	end
endtask

task automatic test_forwarding();
	write_reg(5'd7, 32'h1111_1111);
	write_reg(5'd9, 32'h2222_2222);
	check_itype(OPC_ORI, 5'd7, 5'd9, 16'h0001, 32'h1111_1111);
	mem_we    = 1'b1;
	mem_waddr = 5'd7;
	mem_wdata = 32'h3333_3333;
	check_itype(OPC_ADDI, 5'd7, 5'd9, 16'h8001, 32'h3333_3333);
	// ex and mem on the same register
	ex_we    = 1'b1;
	ex_waddr = 5'd7;
	ex_wdata = 32'h4444_4444;
	check_itype(OPC_ADDI, 5'd7, 5'd9, 16'h8002, 32'h4444_4444);
	ex_waddr = 5'd9;
	check_itype(OPC_SLTI, 5'd7, 5'd9, 16'h7fff, 32'h3333_3333);
	// both ports aim at $zero
	ex_waddr  = 5'd0;
	mem_waddr = 5'd0;
	check_itype(OPC_XORI, 5'd0, 5'd9, 16'hf0f0, ZERO_WORD);
	// write-back and read of r7 in one cycle
	ex_we    = 1'b0;
	mem_we   = 1'b0;
	wb_we    = 1'b1;
	wb_waddr = 5'd7;
	wb_wdata = 32'h5555_5555;
	check_itype(OPC_ANDI, 5'd7, 5'd9, 16'h00ff, 32'h5555_5555);
	wb_we = 1'b0;
	shadow_regs[7] = 32'h5555_5555;
endtask

task automatic test_jumps();
	logic [25:0] index;
	index = 26'h123_4567;
	pc    = 32'ha000_1000;
	inst  = {OPC_J, index};
	step();
	check_outputs(OP_J, ZERO_WORD, ZERO_WORD, 1'b0, 5'd31, expected_target(pc, index));
	// pc+4 crosses into the next 256 MB region
	pc   = 32'h5fff_fffc;
	inst = {OPC_JAL, index};
	step();
	check_outputs(OP_JAL, ZERO_WORD, ZERO_WORD, 1'b1, 5'd31, expected_target(pc, index));
	pc   = 32'hffff_fffc;
	inst = {OPC_J, ~index};
	step();
	check_outputs(OP_J, ZERO_WORD, ZERO_WORD, 1'b0, 5'd31, expected_target(pc, ~index));
endtask

// r-type add, beq and an unused opcode
task automatic test_invalid();
	word_t words [3];
	words = '{32'h012a_4020, 32'h1085_0010, 32'hfc00_0000};
	foreach (words[i]) begin
		inst = words[i];
		step();
		check_outputs(OP_INVALID, ZERO_WORD, ZERO_WORD, 1'b0, 5'd0, ZERO_WORD);
	end
endtask

task automatic test_random();
	reg_addr_t rs;
	for (int r = 1; r < 32; r++) begin
		write_reg(5'(r), $urandom);
	end
	for (int n = 0; n < N_RANDOM; n++) begin
		rs        = 5'($urandom_range(31));
		ex_we     = 1'($urandom_range(1));
		ex_waddr  = ($urandom_range(1) == 1) ? rs : 5'($urandom_range(31));
		ex_wdata  = $urandom;
		mem_we    = 1'($urandom_range(1));
		mem_waddr = ($urandom_range(1) == 1) ? rs : 5'($urandom_range(31));
		mem_wdata = $urandom;
		check_itype(itype_opcode(int'($urandom_range(7))), rs, 5'($urandom_range(31)),
			16'($urandom), expected_operand(rs));
	end
	ex_we  = 1'b0;
	mem_we = 1'b0;
endtask

`endif

// ==== verif/tb_id_stage.sv ====
`timescale 1ns/100ps

module tb_id_stage import cpu_pkg::*; ();

localparam int CLK_PERIOD = 100;
// inputs change this long after the rising edge
localparam int DRIVE_DLY = 10;
localparam int RST_CYCLES = 4;
localparam int N_RANDOM = 40;
// decode, forwarding, jump and invalid tests plus the 31 register fills
localparam int DIRECTED_CYCLES = 25;
localparam int TEST_CYCLES = RST_CYCLES + DIRECTED_CYCLES + 31 + N_RANDOM;
localparam int MARGIN_CYCLES = 20;
localparam int SEED = 64687;

logic      clk;
logic      rst;
word_t     pc;
inst_u     inst;
logic      wb_we;
reg_addr_t wb_waddr;
word_t     wb_wdata;
logic      ex_we;
reg_addr_t ex_waddr;
word_t     ex_wdata;
logic      mem_we;
reg_addr_t mem_waddr;
word_t     mem_wdata;
oper_t     id_ex_op;
word_t     id_ex_reg1;
word_t     id_ex_reg2;
logic      id_ex_we;
reg_addr_t id_ex_waddr;
word_t     id_ex_target;

// expected register file contents, kept in step with every write-back
word_t shadow_regs [32];

id_stage_top u_dut (
	.clk_i          (clk),
	.rst_i          (rst),
	.pc_i           (pc),
	.inst_i         (inst),
	.wb_we_i        (wb_we),
	.wb_waddr_i     (wb_waddr),
	.wb_wdata_i     (wb_wdata),
	.ex_we_i        (ex_we),
	.ex_waddr_i     (ex_waddr),
	.ex_wdata_i     (ex_wdata),
	.mem_we_i       (mem_we),
	.mem_waddr_i    (mem_waddr),
	.mem_wdata_i    (mem_wdata),
	.id_ex_op_o     (id_ex_op),
	.id_ex_reg1_o   (id_ex_reg1),
	.id_ex_reg2_o   (id_ex_reg2),
	.id_ex_we_o     (id_ex_we),
	.id_ex_waddr_o  (id_ex_waddr),
	.id_ex_target_o (id_ex_target)
);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

// advance to the next drive point, outputs of the last edge are settled here
task automatic step();
	@(posedge clk);
	#DRIVE_DLY;
endtask

task automatic check_value(input string name, input word_t actual, input word_t expected);
	if (actual !== expected) begin
		$display("FAIL %s: got 0x%08h expected 0x%08h", name, actual, expected);
		$display("TESTS FAILED");
		$fatal(1, "mismatch on %s", name);
	end
endtask

`include "tb_id_tasks.svh"

// watchdog
initial begin
	#(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
	$display("timeout: test sequence still running after %0d cycles",
		TEST_CYCLES + MARGIN_CYCLES);
	$display("TESTS FAILED");
	$fatal(1, "watchdog expired");
end

initial begin
	void'($urandom(SEED));
	rst       = 1'b1;
	pc        = ZERO_WORD;
	// a live jal sits on the input during reset, only reset keeps id/ex a bubble
	inst      = {OPC_JAL, 26'h2aa_aaaa};
	wb_we     = 1'b0;
	wb_waddr  = '0;
	wb_wdata  = ZERO_WORD;
	ex_we     = 1'b0;
	ex_waddr  = '0;
	ex_wdata  = ZERO_WORD;
	mem_we    = 1'b0;
	mem_waddr = '0;
	mem_wdata = ZERO_WORD;
	foreach (shadow_regs[i]) begin
		shadow_regs[i] = ZERO_WORD;
	end
	repeat (RST_CYCLES) @(posedge clk);
	#DRIVE_DLY;
	rst = 1'b0;
	test_reset();
	test_itype_decode();
	test_forwarding();
	test_jumps();
	test_invalid();
	test_random();
	$display("TESTS PASSED");
	$finish;
end

endmodule

// ==== sim.f ====
+incdir+verif
logic/cpu_pkg.sv
logic/id_type_i.sv
logic/id_type_j.sv
logic/regfile.sv
logic/cpu_id.sv
logic/id_stage_top.sv
verif/tb_id_stage.sv

// ==== Makefile ====
TOP := tb_id_stage
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir

# the simulator exit status is lost in the pipe, the grep decides
run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
